// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_writeback
FILELIST = all.f
OBJ_DIR  = obj_dir

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+verilog
verilog/wb_pkg.sv
verilog/load_align.sv
verilog/gpr_file.sv
verilog/csr_file.sv
verilog/pipeline_writeback.sv
verilog/writeback_top.sv
test/tb_clock_gen.sv
test/tb_writeback.sv

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
/*
 * Testbench clock and reset
 * Free running clock, active low reset held for the first cycles
 */
module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk = 1'b0;
        forever #(PERIOD / 2) g_clk = ~g_clk;
    end

    initial begin
        g_resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;                                // Release away from the edge
    end

endmodule

// File: test/tb_writeback.sv
`timescale 1ns/1ps
/*
 * Writeback testbench
 * Random instructions through the stage with inline control-flow and
 * data responders, a GPR and CSR reference model, and a watchdog
 */
`include "wb_settings.svh"

module tb_writeback import wb_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int N_INSTR      = 104;                  // Sum of all sections below

    logic        g_clk, g_resetn;
    reg_addr_t   s4_rd, rs1_addr, rs2_addr, fwd_s4_rd;
    xlen_t       s4_opr_a, s4_opr_b, s4_pc, dmem_rdata, cf_target, trs_pc;
    xlen_t       fwd_s4_wdata, rs1_rdata, rs2_rdata;
    uop_t        s4_uop;
    fu_t         s4_fu;
    logic [1:0]  s4_size;
    logic [31:0] s4_instr, trs_instr;
    logic        s4_p_valid, s4_p_busy, fwd_s4_load, fwd_s4_csr;
    logic        cf_req, cf_ack, dmem_recv, dmem_ack, dmem_error, hold_lsu_req, trs_valid;

    // Reference model state
    xlen_t     gpr_m [0:31];
    xlen_t     mscratch_m, mepc_m, mcause_m, mtvec_m;
    integer    seed;
    xlen_t     next_pc, last_pc, last_fwd;
    reg_addr_t last_rd;
    int        issued, trs_count;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    writeback_top u_writeback_top (.*);

    // ------------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_cause(input string name, input trap_cause_t got,
                               input trap_cause_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    function automatic xlen_t rand_word();
        return $random(seed);
    endfunction

    function automatic fu_t fu_onehot(input int idx);
        return fu_t'(1 << idx);
    endfunction

    function automatic uop_t lsu_uop(input logic load, input logic store,
                                     input lsu_size_t size, input logic sgn);
        uop_t u;
        u = '0;
        u[LSU_LOAD]        = load;
        u[LSU_STORE]       = store;
        u[LSU_SIZE +: 2]   = size;
        u[LSU_SIGNED]      = sgn;
        return u;
    endfunction

    function automatic uop_t csr_uop(input logic wr, input logic set, input logic clr);
        uop_t u;
        u = '0;
        u[CSR_READ]  = 1'b1;                            // Always return the old value
        u[CSR_WRITE] = wr;
        u[CSR_SET]   = set;
        u[CSR_CLEAR] = clr;
        return u;
    endfunction

    function automatic xlen_t csr_model(input csr_addr_t addr);
        case (addr)
            CSR_MTVEC:    return mtvec_m;
            CSR_MSCRATCH: return mscratch_m;
            CSR_MEPC:     return mepc_m;
            CSR_MCAUSE:   return mcause_m;
            default:      return '0;
        endcase
    endfunction

    // Shift the addressed lane down, then mask and extend
    function automatic xlen_t align_load(input xlen_t word, input logic [1:0] off,
                                         input lsu_size_t size, input logic sgn);
        xlen_t v;
        case (size)
            LSU_BYTE: begin
                v = (word >> (8 * int'(off))) & 32'h0000_00ff;
                if (sgn && v[7]) v = v | 32'hffff_ff00;
            end
            LSU_HALF: begin
                v = (word >> (16 * int'(off[1]))) & 32'h0000_ffff;
                if (sgn && v[15]) v = v | 32'hffff_0000;
            end
            default: v = word;
        endcase
        return v;
    endfunction

    // Expected rd value, control-flow target and trap cause
    function automatic void predict(input fu_t fu, input uop_t uop, input xlen_t a,
                                    input xlen_t b, input xlen_t rdata, input logic err,
                                    output logic wen, output xlen_t wdata,
                                    output logic cf, output xlen_t target,
                                    output logic trap, output trap_cause_t cause);
        wen    = 1'b0;
        wdata  = '0;
        cf     = 1'b0;
        target = '0;
        trap   = 1'b0;
        cause  = '0;
        if (fu[FU_ALU] || fu[FU_MUL]) begin
            wen   = 1'b1;
            wdata = a;
        end else if (fu[FU_CSR]) begin
            wen   = uop[CSR_READ];
            wdata = csr_model(b[11:0]);
        end else if (fu[FU_LSU]) begin
            if (err) begin
                trap   = 1'b1;
                cf     = 1'b1;
                target = mtvec_m;
                cause  = uop[LSU_LOAD] ? TRAP_LDACCESS : TRAP_STACCESS;
            end else if (uop[LSU_LOAD]) begin
                wen   = 1'b1;
                wdata = align_load(rdata, b[1:0], uop[LSU_SIZE +: 2], uop[LSU_SIGNED]);
            end
        end else if (fu[FU_CFU]) begin
            cf = 1'b1;
            case (uop)
                CFU_TAKEN: begin
                    target = a;
                end
                CFU_JALI, CFU_JALR: begin
                    target = a;
                    wen    = 1'b1;
                    wdata  = b;
                end
                CFU_ECALL: begin
                    target = mtvec_m;
                    trap   = 1'b1;
                    cause  = TRAP_ECALLM;
                end
                CFU_EBREAK: begin
                    target = mtvec_m;
                    trap   = 1'b1;
                    cause  = TRAP_BREAKPT;
                end
                default: begin
                    target = mepc_m;                    // MRET
                end
            endcase
        end
    endfunction

    // ------------------------------------------------------------------------
    // Issue one instruction, answer its requests, check it and update the model
    task automatic run_instr(input fu_t fu, input uop_t uop, input reg_addr_t rd,
                             input xlen_t a, input xlen_t b, input xlen_t rdata,
                             input logic err);
        int unsigned d_cf, d_mem, k;
        logic        exp_wen, exp_cf, exp_trap, retired;
        xlen_t       exp_wdata, exp_target, pc, rnd, csr_new;
        logic [31:0] instr;
        trap_cause_t exp_cause;
        pc      = next_pc;
        next_pc = next_pc + 4;
        predict(fu, uop, a, b, rdata, err, exp_wen, exp_wdata, exp_cf, exp_target,
                exp_trap, exp_cause);
        d_cf    = rand_word() % 4;
        d_mem   = rand_word() % 4;
        k       = 0;
        retired = 1'b0;
        rnd     = rand_word();
        instr   = rand_word();
        @(negedge g_clk);
        s4_fu      = fu;
        s4_uop     = uop;
        s4_rd      = rd;
        s4_opr_a   = a;
        s4_opr_b   = b;
        s4_pc      = pc;
        s4_instr   = instr;
        s4_size    = 2'b11;
        s4_p_valid = 1'b1;
        dmem_rdata = rdata;
        dmem_error = err;
        cf_ack     = (d_cf == 0);
        dmem_recv  = (d_mem == 0);
        rs1_addr   = last_rd;
        rs2_addr   = rnd[4:0];
        while (!retired) begin
            #1;                                         // Let the stage settle
            if (k == 0) begin
                check_word("rs1_rdata", rs1_rdata, gpr_m[rs1_addr]);
                check_word("rs2_rdata", rs2_rdata, gpr_m[rs2_addr]);
            end
            if (trs_valid) trs_count++;
            if (cf_req) check_word("cf_target", cf_target, exp_target);
            if (fu[FU_LSU] && !dmem_recv) begin
                check_flag("dmem_ack", dmem_ack, 1'b1);
                check_flag("s4_p_busy", s4_p_busy, 1'b1);
                check_flag("hold_lsu_req", hold_lsu_req, 1'b1);
            end
            if (!s4_p_busy) begin
                check_flag("trs_valid", trs_valid, 1'b1);
                check_word("trs_pc", trs_pc, pc);
                check_word("trs_instr", trs_instr, instr);
                check_flag("cf_req", cf_req, exp_cf);
                check_flag("hold_lsu_req", hold_lsu_req, exp_cf);
                check_flag("fwd_s4_load", fwd_s4_load, fu[FU_LSU] && uop[LSU_LOAD]);
                check_flag("fwd_s4_csr", fwd_s4_csr, fu[FU_CSR]);
                check_addr("fwd_s4_rd", fwd_s4_rd, rd);
                if (exp_wen) check_word("fwd_s4_wdata", fwd_s4_wdata, exp_wdata);
                last_fwd = fwd_s4_wdata;
                retired  = 1'b1;
            end else begin
                @(negedge g_clk);
                k++;
                cf_ack    = (k >= d_cf);
                dmem_recv = (k >= d_mem);
            end
        end
        if (exp_wen && rd != '0) gpr_m[rd] = exp_wdata;
        if (exp_trap) begin
            mepc_m   = pc;
            mcause_m = {26'b0, exp_cause};
        end else if (fu[FU_CSR] && b[11:0] == CSR_MSCRATCH) begin
            csr_new = mscratch_m;
            if (uop[CSR_WRITE]) csr_new = a;
            if (uop[CSR_SET])   csr_new = mscratch_m | a;
            if (uop[CSR_CLEAR]) csr_new = mscratch_m & ~a;
            mscratch_m = csr_new;
        end
        last_rd = rd;
        last_pc = pc;
        issued++;
    endtask

    task automatic read_csr(input csr_addr_t addr);
        xlen_t r;
        r = rand_word();
        run_instr(fu_onehot(FU_CSR), csr_uop(1'b0, 1'b0, 1'b0),
                  reg_addr_t'({1'b0, r[3:0]} + 5'd1), '0, {20'b0, addr}, '0, 1'b0);
    endtask

    // Trap, then read mepc and mcause, then return with MRET
    task automatic trap_round(input fu_t fu, input uop_t uop, input logic err,
                              input trap_cause_t cause);
        xlen_t trap_pc;
        xlen_t r;
        r = rand_word();
        run_instr(fu, uop, r[4:0], rand_word(), rand_word(), rand_word(), err);
        trap_pc = last_pc;
        read_csr(CSR_MEPC);
        check_word("mepc", last_fwd, trap_pc);
        read_csr(CSR_MCAUSE);
        check_cause("mcause", last_fwd[5:0], cause);
        check_word("mcause upper", last_fwd & 32'hffff_ffc0, '0);
        run_instr(fu_onehot(FU_CFU), CFU_MRET, '0, '0, '0, '0, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    initial begin
        #((N_INSTR * 20 + RESET_CYCLES + 8) * CLK_PERIOD);
        abort_run("Watchdog expired: the DUT stopped retiring instructions");
    end

    initial begin
        xlen_t r;
        seed       = 32'h6f48_144f;
        s4_rd      = '0;
        s4_opr_a   = '0;
        s4_opr_b   = '0;
        s4_pc      = '0;
        s4_uop     = '0;
        s4_fu      = '0;
        s4_size    = '0;
        s4_instr   = '0;
        s4_p_valid = 1'b0;
        cf_ack     = 1'b0;
        dmem_recv  = 1'b0;
        dmem_error = 1'b0;
        dmem_rdata = '0;
        rs1_addr   = '0;
        rs2_addr   = '0;
        for (int i = 0; i < 32; i++) gpr_m[i] = '0;
        mscratch_m = '0;
        mepc_m     = `WB_MEPC_RESET;
        mcause_m   = '0;
        mtvec_m    = `WB_MTVEC_RESET;
        next_pc    = 32'h0000_1000;
        last_rd    = '0;
        issued     = 0;
        trs_count  = 0;

        @(posedge g_resetn);
        #1;
        check_flag("s4_p_busy", s4_p_busy, 1'b0);
        check_flag("cf_req", cf_req, 1'b0);
        check_flag("dmem_ack", dmem_ack, 1'b0);
        check_flag("trs_valid", trs_valid, 1'b0);
        check_flag("hold_lsu_req", hold_lsu_req, 1'b0);

        // ALU, MUL, JAL and JALR results
        for (int i = 0; i < 40; i++) begin
            r = rand_word();
            case (r[1:0])
                2'd0: run_instr(fu_onehot(FU_ALU), '0, r[8:4], rand_word(), '0, '0, 1'b0);
                2'd1: run_instr(fu_onehot(FU_MUL), '0, r[8:4], rand_word(), '0, '0, 1'b0);
                2'd2: run_instr(fu_onehot(FU_CFU), CFU_JALI, r[8:4], rand_word(), rand_word(),
                                '0, 1'b0);
                default: run_instr(fu_onehot(FU_CFU), CFU_JALR, r[8:4], rand_word(),
                                   rand_word(), '0, 1'b0);
            endcase
        end

        // Loads of every size, sign and offset, then plain stores
        for (int sz = 1; sz < 4; sz++) begin
            for (int sg = 0; sg < 2; sg++) begin
                for (int off = 0; off < 4; off++) begin
                    r = rand_word();
                    run_instr(fu_onehot(FU_LSU), lsu_uop(1'b1, 1'b0, lsu_size_t'(sz), sg[0]),
                              r[4:0], rand_word(), {r[31:2], off[1:0]}, rand_word(), 1'b0);
                end
            end
        end
        for (int i = 0; i < 4; i++) begin
            run_instr(fu_onehot(FU_LSU), lsu_uop(1'b0, 1'b1, LSU_WORD, 1'b0), '0,
                      rand_word(), rand_word(), rand_word(), 1'b0);
        end

        // Write, set and clear on mscratch
        for (int i = 0; i < 12; i++) begin
            r = rand_word();
            run_instr(fu_onehot(FU_CSR), csr_uop(i % 3 == 0, i % 3 == 1, i % 3 == 2),
                      r[4:0], rand_word(), {20'b0, CSR_MSCRATCH}, '0, 1'b0);
        end

        for (int i = 0; i < 8; i++) begin
            run_instr(fu_onehot(FU_CFU), CFU_TAKEN, '0, rand_word(), '0, '0, 1'b0);
        end

        trap_round(fu_onehot(FU_CFU), CFU_ECALL, 1'b0, 6'd11);
        trap_round(fu_onehot(FU_CFU), CFU_EBREAK, 1'b0, 6'd3);
        trap_round(fu_onehot(FU_LSU), lsu_uop(1'b1, 1'b0, LSU_WORD, 1'b0), 1'b1, 6'd5);
        trap_round(fu_onehot(FU_LSU), lsu_uop(1'b0, 1'b1, LSU_WORD, 1'b0), 1'b1, 6'd7);

        // Idle cycle to read back the last destination
        @(negedge g_clk);
        s4_p_valid = 1'b0;
        cf_ack     = 1'b0;
        dmem_recv  = 1'b0;
        rs1_addr   = last_rd;
        #1;
        check_word("rs1_rdata", rs1_rdata, gpr_m[rs1_addr]);
        check_flag("trs_valid", trs_valid, 1'b0);

        if (trs_count == issued && issued == N_INSTR) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run($sformatf("Trace count %0d does not match %0d issued instructions",
                                trs_count, issued));
        end
    end

endmodule

// File: verilog/csr_file.sv
`timescale 1ns/1ps
/*
 * Machine CSR file
 * mscratch, mepc, mcause and mtvec with write, set and clear access
 * and capture of trap state
 */
`include "wb_settings.svh"

module csr_file import wb_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        csr_en,     // Access enable
    input  logic        csr_wr,     // Replace value
    input  logic        csr_wr_set, // OR in data bits
    input  logic        csr_wr_clr, // Clear data bits
    input  csr_addr_t   csr_addr,
    input  xlen_t       csr_wdata,
    output xlen_t       csr_rdata,  // Old value of addressed CSR
    input  logic        trap_take,  // Trap accepted this cycle
    input  trap_cause_t trap_cause,
    input  xlen_t       trap_pc,
    input  logic        exec_mret,  // MRET retiring
    output xlen_t       csr_mtvec,
    output xlen_t       csr_mepc
);

    xlen_t mscratch, mepc, mcause, mtvec;
    xlen_t csr_new;
    logic  csr_write;

    always_comb begin
        case (csr_addr)
            CSR_MTVEC:    csr_rdata = mtvec;
            CSR_MSCRATCH: csr_rdata = mscratch;
            CSR_MEPC:     csr_rdata = mepc;
            CSR_MCAUSE:   csr_rdata = mcause;
            default:      csr_rdata = '0;               // Unimplemented
        endcase
    end

    // New value from the old one and the access type
    always_comb begin
        csr_new = csr_rdata;
        if (csr_wr) begin
            csr_new = csr_wdata;
        end else if (csr_wr_set) begin
            csr_new = csr_rdata | csr_wdata;
        end else if (csr_wr_clr) begin
            csr_new = csr_rdata & ~csr_wdata;
        end
    end

    assign csr_write = csr_en && (csr_wr || csr_wr_set || csr_wr_clr);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch <= '0;
            mepc     <= `WB_MEPC_RESET;
            mcause   <= '0;
            mtvec    <= `WB_MTVEC_RESET;
        end else if (trap_take) begin
            mepc     <= trap_pc;                        // Trap wins over access
            mcause   <= xlen_t'(trap_cause);
        end else if (csr_write) begin
            case (csr_addr)
                CSR_MTVEC:    mtvec    <= csr_new;
                CSR_MSCRATCH: mscratch <= csr_new;
                CSR_MEPC:     mepc     <= csr_new;
                CSR_MCAUSE:   mcause   <= csr_new;
                default:      ;
            endcase
        end
    end

    assign csr_mtvec = mtvec;
    assign csr_mepc  = mepc;

    // ------------------------------------------------------------------------
    a_one_access: assert property (@(posedge g_clk) disable iff (!g_resetn)
        csr_en |-> $onehot0({csr_wr, csr_wr_set, csr_wr_clr}));

    // MRET and a trap never retire together
    a_mret_trap: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(exec_mret && trap_take));

endmodule

// File: verilog/gpr_file.sv
`timescale 1ns/1ps
/*
 * General purpose registers
 * 31 writable registers, x0 reads zero, two combinational read ports
 */
module gpr_file import wb_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      wen,       // Write enable
    input  reg_addr_t rd,        // Write index
    input  xlen_t     wdata,     // Write data
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_rdata,
    output xlen_t     rs2_rdata
);

    xlen_t regs [1:31];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= wdata;                          // x0 writes dropped
        end
    end

    assign rs1_rdata = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_rdata = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: verilog/load_align.sv
`timescale 1ns/1ps
/*
 * Load alignment
 * Picks the addressed byte, half or word out of a read word and extends it
 */
`include "wb_settings.svh"

module load_align import wb_pkg::*; (
    input  xlen_t      rdata,     // Raw read word
    input  logic [1:0] addr_lo,   // Low address bits
    input  lsu_size_t  size,      // Access size
    input  logic       is_signed, // Sign extend
    output xlen_t      data       // Aligned result
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // Misaligned halves fall back to their own half of the word
    assign byte_sel = rdata[{addr_lo, 3'b000} +: 8];
    assign half_sel = rdata[{addr_lo[1], 4'b0000} +: 16];

    always_comb begin
        case (size)
            LSU_BYTE: begin
                data = {{(`WB_XLEN-8){is_signed && byte_sel[7]}}, byte_sel};
            end
            LSU_HALF: begin
                data = {{(`WB_XLEN-16){is_signed && half_sel[15]}}, half_sel};
            end
            default: begin
                data = rdata;                           // Whole word
            end
        endcase
    end

endmodule

// File: verilog/pipeline_writeback.sv
`timescale 1ns/1ps
/*
 * Writeback stage
 * Retires one instruction from stage four: GPR writeback, CSR access,
 * control-flow requests, load completion, bus-error traps and trace
 */
module pipeline_writeback import wb_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  reg_addr_t   s4_rd,        // Destination register
    input  xlen_t       s4_opr_a,
    input  xlen_t       s4_opr_b,
    input  xlen_t       s4_pc,
    input  uop_t        s4_uop,
    input  fu_t         s4_fu,        // One-hot unit select
    input  logic [1:0]  s4_size,      // Instruction size, zero for a bubble
    input  logic [31:0] s4_instr,
    input  logic        s4_p_valid,
    output logic        s4_p_busy,
    output reg_addr_t   fwd_s4_rd,
    output xlen_t       fwd_s4_wdata,
    output logic        fwd_s4_load,
    output logic        fwd_s4_csr,
    output logic        gpr_wen,
    output reg_addr_t   gpr_rd,
    output xlen_t       gpr_wdata,
    output logic        csr_en,
    output logic        csr_wr,
    output logic        csr_wr_set,
    output logic        csr_wr_clr,
    output csr_addr_t   csr_addr,
    output xlen_t       csr_wdata,
    input  xlen_t       csr_rdata,
    input  xlen_t       csr_mtvec,
    input  xlen_t       csr_mepc,
    output logic        trap_take,
    output trap_cause_t trap_cause,
    output xlen_t       trap_pc,
    output logic        exec_mret,
    output logic        cf_req,
    output xlen_t       cf_target,
    input  logic        cf_ack,
    input  logic        dmem_recv,
    input  logic        dmem_error,
    input  xlen_t       dmem_rdata,
    output logic        dmem_ack,
    output logic        hold_lsu_req,
    output xlen_t       trs_pc,
    output logic [31:0] trs_instr,
    output logic        trs_valid
);

    logic  pipe_progress;
    logic  fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic  csr_done, csr_gpr_wen;
    logic  cfu_taken, cfu_link, cfu_ecall, cfu_ebreak, cfu_mret, cfu_trap;
    logic  cfu_done;
    logic  lsu_load, lsu_store, lsu_resp, lsu_busy, lsu_trap;
    logic  lsu_rsp_seen, lsu_err_seen;
    logic  any_trap;
    xlen_t lsu_rdata;

    assign pipe_progress = s4_p_valid && !s4_p_busy;    // Retire cycle
    assign s4_p_busy     = (cf_req && !cf_ack) || lsu_busy;
    assign hold_lsu_req  = cf_req || lsu_busy;

    // ------------------------------------------------------------------------
    // Unit decode, idle stage selects nothing
    assign fu_alu = s4_p_valid && s4_fu[FU_ALU];
    assign fu_mul = s4_p_valid && s4_fu[FU_MUL];
    assign fu_lsu = s4_p_valid && s4_fu[FU_LSU];
    assign fu_cfu = s4_p_valid && s4_fu[FU_CFU];
    assign fu_csr = s4_p_valid && s4_fu[FU_CSR];

    // ------------------------------------------------------------------------
    // CSR access, once per instruction
    assign csr_en      = fu_csr && !csr_done;
    assign csr_wr      = csr_en && s4_uop[CSR_WRITE];
    assign csr_wr_set  = csr_en && s4_uop[CSR_SET];
    assign csr_wr_clr  = csr_en && s4_uop[CSR_CLEAR];
    assign csr_addr    = s4_opr_b[11:0];
    assign csr_wdata   = s4_opr_a;
    assign csr_gpr_wen = csr_en && s4_uop[CSR_READ];

    // ------------------------------------------------------------------------
    // Control flow
    assign cfu_link   = fu_cfu && (s4_uop == CFU_JALI || s4_uop == CFU_JALR);
    assign cfu_taken  = cfu_link || (fu_cfu && s4_uop == CFU_TAKEN);
    assign cfu_ecall  = fu_cfu && s4_uop == CFU_ECALL;
    assign cfu_ebreak = fu_cfu && s4_uop == CFU_EBREAK;
    assign cfu_mret   = fu_cfu && s4_uop == CFU_MRET;
    assign cfu_trap   = cfu_ecall || cfu_ebreak;
    assign any_trap   = cfu_trap || lsu_trap;

    assign cf_req    = (cfu_taken || cfu_mret || any_trap) && !cfu_done;
    assign cf_target = cfu_taken ? s4_opr_a :
                       cfu_mret  ? csr_mepc : csr_mtvec; // Traps to mtvec
    assign exec_mret = cfu_mret && pipe_progress;

    // ------------------------------------------------------------------------
    // Data response
    assign lsu_load  = fu_lsu && s4_uop[LSU_LOAD];
    assign lsu_store = fu_lsu && s4_uop[LSU_STORE];
    assign dmem_ack  = fu_lsu && !lsu_rsp_seen;          // Response outstanding
    assign lsu_resp  = dmem_recv && dmem_ack;
    assign lsu_busy  = dmem_ack && !dmem_recv;

    // Error stays raised until the trap request is taken
    assign lsu_trap = (lsu_resp && dmem_error) ||
                      (fu_lsu && lsu_rsp_seen && lsu_err_seen);

    load_align u_load_align (
        .rdata     (dmem_rdata),
        .addr_lo   (s4_opr_b[1:0]),
        .size      (s4_uop[LSU_SIZE +: 2]),
        .is_signed (s4_uop[LSU_SIGNED]),
        .data      (lsu_rdata)
    );

    // Done flags clear when the instruction retires
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            csr_done     <= 1'b0;
            cfu_done     <= 1'b0;
            lsu_rsp_seen <= 1'b0;
            lsu_err_seen <= 1'b0;
        end else begin
            csr_done     <= !pipe_progress && (csr_done || csr_en);
            cfu_done     <= !pipe_progress && (cfu_done || (cf_req && cf_ack));
            lsu_rsp_seen <= !pipe_progress && (lsu_rsp_seen || lsu_resp);
            if (lsu_resp) begin
                lsu_err_seen <= dmem_error;
            end
        end
    end

    // ------------------------------------------------------------------------
    // GPR writeback and forwarding
    assign gpr_rd  = s4_rd;
    assign gpr_wen = pipe_progress && !any_trap && s4_rd != '0 &&
                     (fu_alu || fu_mul || csr_gpr_wen || lsu_load || cfu_link);

    always_comb begin
        if (fu_csr) begin
            gpr_wdata = csr_rdata;                      // Old CSR value
        end else if (fu_lsu) begin
            gpr_wdata = lsu_rdata;
        end else if (fu_cfu) begin
            gpr_wdata = s4_opr_b;                       // Link address
        end else begin
            gpr_wdata = s4_opr_a;                       // ALU and MUL result
        end
    end

    assign fwd_s4_rd    = s4_rd;
    assign fwd_s4_wdata = gpr_wdata;
    assign fwd_s4_load  = lsu_load;
    assign fwd_s4_csr   = fu_csr;

    // ------------------------------------------------------------------------
    // Traps and trace
    assign trap_take  = any_trap && pipe_progress;
    assign trap_pc    = s4_pc;
    assign trap_cause = (lsu_trap && lsu_load)  ? TRAP_LDACCESS :
                        (lsu_trap && lsu_store) ? TRAP_STACCESS :
                        cfu_ebreak              ? TRAP_BREAKPT  :
                        cfu_ecall               ? TRAP_ECALLM   : '0;

    assign trs_pc    = s4_pc;
    assign trs_instr = s4_instr;
    assign trs_valid = pipe_progress && s4_size != 2'b00;

    // Upstream holds its inputs while stalled, so the target must too
    a_cf_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> cf_req && $stable(cf_target));

endmodule

// File: verilog/wb_pkg.sv
/*
 * Writeback package
 * Vector types, unit selects, micro-op codes, CSR addresses and causes
 */
`include "wb_settings.svh"

package wb_pkg;

    typedef logic [`WB_XLEN-1:0] xlen_t;
    typedef logic [4:0]          reg_addr_t;
    typedef logic [4:0]          fu_t;
    typedef logic [4:0]          uop_t;
    typedef logic [11:0]         csr_addr_t;
    typedef logic [5:0]          trap_cause_t;
    typedef logic [1:0]          lsu_size_t;

    // ------------------------------------------------------------------------
    // Functional unit bits of fu_t
    localparam int FU_ALU = 0;
    localparam int FU_MUL = 1;
    localparam int FU_LSU = 2;
    localparam int FU_CFU = 3;
    localparam int FU_CSR = 4;

    // CSR micro-op bits
    localparam int CSR_READ  = 4;
    localparam int CSR_WRITE = 3;
    localparam int CSR_SET   = 2;
    localparam int CSR_CLEAR = 1;

    // LSU micro-op bits, size field sits at [LSU_SIZE +: 2]
    localparam int LSU_SIGNED = 0;
    localparam int LSU_SIZE   = 1;
    localparam int LSU_LOAD   = 3;
    localparam int LSU_STORE  = 4;

    localparam lsu_size_t LSU_BYTE = 2'b01;
    localparam lsu_size_t LSU_HALF = 2'b10;
    localparam lsu_size_t LSU_WORD = 2'b11;

    // CFU micro-op codes
    localparam uop_t CFU_TAKEN  = 5'd1;
    localparam uop_t CFU_JALI   = 5'd2;
    localparam uop_t CFU_JALR   = 5'd3;
    localparam uop_t CFU_ECALL  = 5'd4;
    localparam uop_t CFU_EBREAK = 5'd5;
    localparam uop_t CFU_MRET   = 5'd6;

    // ------------------------------------------------------------------------
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    localparam trap_cause_t TRAP_BREAKPT  = 6'd3;
    localparam trap_cause_t TRAP_LDACCESS = 6'd5;
    localparam trap_cause_t TRAP_STACCESS = 6'd7;
    localparam trap_cause_t TRAP_ECALLM   = 6'd11;

endpackage

// File: verilog/wb_settings.svh
/*
 * Writeback settings
 * Data width and machine CSR reset values
 */
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Data path width
`define WB_XLEN 32

// Machine CSR state after reset
`define WB_MTVEC_RESET 32'h0000_0080 // Trap vector
`define WB_MEPC_RESET  32'h0000_0000 // Exception PC

`endif

// File: verilog/writeback_top.sv
`timescale 1ns/1ps
/*
 * Writeback top
 * Writeback stage with its GPR file and machine CSR file
 */
module writeback_top import wb_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  reg_addr_t   s4_rd,
    input  xlen_t       s4_opr_a,
    input  xlen_t       s4_opr_b,
    input  xlen_t       s4_pc,
    input  uop_t        s4_uop,
    input  fu_t         s4_fu,
    input  logic [1:0]  s4_size,
    input  logic [31:0] s4_instr,
    input  logic        s4_p_valid,
    output logic        s4_p_busy,
    output reg_addr_t   fwd_s4_rd,
    output xlen_t       fwd_s4_wdata,
    output logic        fwd_s4_load,
    output logic        fwd_s4_csr,
    output logic        cf_req,
    output xlen_t       cf_target,
    input  logic        cf_ack,
    input  logic        dmem_recv,
    output logic        dmem_ack,
    input  logic        dmem_error,
    input  xlen_t       dmem_rdata,
    output logic        hold_lsu_req,
    output xlen_t       trs_pc,
    output logic [31:0] trs_instr,
    output logic        trs_valid,
    input  reg_addr_t   rs1_addr,
    output xlen_t       rs1_rdata,
    input  reg_addr_t   rs2_addr,
    output xlen_t       rs2_rdata
);

    // Stage to register file
    logic        gpr_wen;
    reg_addr_t   gpr_rd;
    xlen_t       gpr_wdata;

    // Stage to CSR file
    logic        csr_en, csr_wr, csr_wr_set, csr_wr_clr;
    csr_addr_t   csr_addr;
    xlen_t       csr_wdata, csr_rdata, csr_mtvec, csr_mepc;
    logic        trap_take, exec_mret;
    trap_cause_t trap_cause;
    xlen_t       trap_pc;

    // Port names match one to one
    pipeline_writeback u_pipeline_writeback (.*);

    gpr_file u_gpr_file (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .wen       (gpr_wen),
        .rd        (gpr_rd),
        .wdata     (gpr_wdata),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata)
    );

    csr_file u_csr_file (.*);

endmodule
